//--- src/flash_consts.svh
`ifndef FLASH_CONSTS_SVH
`define FLASH_CONSTS_SVH

// Host and SDRAM bus widths.
`define FLASH_ADDR_W 23
`define SDRAM_ADDR_W 27

// Erase sector size is 2^FLASH_SECTOR_SHIFT bytes.
`define FLASH_SECTOR_SHIFT 12

`define WRITE_FIFO_DEPTH 4

// Unlock addresses, compared against host address bits 11:1.
`define UNLOCK_ADDR_A 11'h555
`define UNLOCK_ADDR_B 11'h2AA

// Identify responses, selected by host address bits 2:1.
`define ID_BYTE_0 8'h20
`define ID_BYTE_1 8'h7E
`define ID_BYTE_2 8'h00
`define ID_BYTE_3 8'h01

`endif

//--- src/flash_pkg.sv
`include "flash_consts.svh"

package flash_pkg;

	// *********************************************************************
	// Host side
	// *********************************************************************

	// Host request as sampled every cycle.
	typedef struct packed {
		logic [`FLASH_ADDR_W-1:0] addr;
		logic [7:0]               din;
		logic                     we;
		logic                     ce;
	} host_bus_t;

	// *********************************************************************
	// Memory work
	// *********************************************************************

	typedef enum logic {
		WR_PROGRAM,
		WR_ERASE
	} write_kind_t;

	// One unit of memory work. The addr field is the host byte address.
	typedef struct packed {
		write_kind_t              kind;
		logic [`FLASH_ADDR_W-1:0] addr;
		logic [7:0]               data;
	} write_item_t;

endpackage

//--- src/flash_cmd_decoder.sv
`timescale 1ns/1ps
`include "flash_consts.svh"

module flash_cmd_decoder
	import flash_pkg::*;
(
	input  logic        clk,
	input  logic        reset,
	input  host_bus_t   host,
	input  logic        busy,
	output logic [7:0]  dout,
	output logic        data_valid,
	output write_item_t item,
	output logic        push,
	input  logic        full,
	output logic        overflow
);

	logic        old_we;
	logic [2:0]  index;
	logic [7:0]  cmd [5];
	logic        identify;
	logic [2:0]  prog_cnt;

	logic        strobe;
	logic        prog_write;
	logic        cmd_write;
	logic [10:0] unlock_addr;
	logic        addr_ok;
	logic        byte_ok;
	logic        seq_ok;
	logic        erase_done;
	logic        push_due;

	// *********************************************************************
	// Write strobe and sequence matching
	// *********************************************************************

	assign strobe = host.we & host.ce & ~old_we;

	// While a program count is pending, a strobe carries data and not a command.
	assign prog_write = strobe & (prog_cnt != 3'd0);
	assign cmd_write  = strobe & (prog_cnt == 3'd0);

	assign unlock_addr = (index == 3'd1 || index == 3'd4) ? `UNLOCK_ADDR_B : `UNLOCK_ADDR_A;
	assign addr_ok = (host.addr[11:1] == unlock_addr) ||
		(index == 3'd0 && host.din == 8'hF0); // Reset may come from any address.

	// Each position checks the new byte and the byte stored before it.
	always_comb begin
		case (index)
			3'd0: byte_ok = host.din == 8'hF0 || host.din == 8'h50 ||
				host.din == 8'h56 || host.din == 8'hAA;
			3'd1: byte_ok = cmd[0] == 8'hAA && host.din == 8'h55;
			3'd2: byte_ok = cmd[1] == 8'h55 && (host.din == 8'h80 ||
				host.din == 8'h90 || host.din == 8'hA0);
			3'd3: byte_ok = cmd[2] == 8'h80 && host.din == 8'hAA;
			3'd4: byte_ok = cmd[3] == 8'hAA && host.din == 8'h55;
			3'd5: byte_ok = cmd[4] == 8'h55 && (host.din == 8'h30 || host.din == 8'h10);
			default: byte_ok = 1'b0;
		endcase
	end

	assign seq_ok = addr_ok & byte_ok;
	assign erase_done = cmd_write & seq_ok & (index == 3'd5) & (host.din == 8'h30);

	// *********************************************************************
	// Write item output
	// *********************************************************************

	assign push_due = prog_write | erase_done;
	assign push = push_due & ~full; // A full FIFO drops the item.

	assign item.kind = erase_done ? WR_ERASE : WR_PROGRAM;
	assign item.addr = host.addr;
	assign item.data = host.din;

	// *********************************************************************
	// Sequence state
	// *********************************************************************

	always_ff @(posedge clk) begin
		if (reset) begin
			old_we   <= 1'b0;
			index    <= 3'd0;
			identify <= 1'b0;
			prog_cnt <= 3'd0;
			overflow <= 1'b0;
		end else begin
			old_we <= host.we;
			if (push_due && full)
				overflow <= 1'b1;
			if (prog_write)
				prog_cnt <= prog_cnt - 3'd1;
			if (cmd_write) begin
				if (!seq_ok) begin
					index <= 3'd0;
				end else begin
					index <= index + 3'd1;
					if (index == 3'd0) begin
						case (host.din)
							8'hF0: begin
								identify <= 1'b0;
								index    <= 3'd0;
							end
							8'h50: begin
								prog_cnt <= 3'd2;
								index    <= 3'd0;
							end
							8'h56: begin
								prog_cnt <= 3'd4;
								index    <= 3'd0;
							end
							default: ;
						endcase
					end
					if (index == 3'd2 && host.din == 8'h90) begin
						identify <= 1'b1;
						index    <= 3'd0;
					end
					if (index == 3'd2 && host.din == 8'hA0) begin
						prog_cnt <= 3'd1;
						index    <= 3'd0;
					end
					if (index == 3'd5)
						index <= 3'd0; // Erase is pushed, chip erase is ignored.
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (cmd_write && seq_ok && index < 3'd5)
			cmd[index] <= host.din;
	end

	// *********************************************************************
	// Read data
	// *********************************************************************

	always_comb begin
		if (!host.ce) begin
			dout = 8'hFF;
		end else if (busy) begin
			dout = 8'h00; // Erase in progress.
		end else if (identify) begin
			case (host.addr[2:1])
				2'd0: dout = `ID_BYTE_0;
				2'd1: dout = `ID_BYTE_1;
				2'd2: dout = `ID_BYTE_2;
				default: dout = `ID_BYTE_3;
			endcase
		end else begin
			dout = 8'hFF;
		end
	end

	// Array data itself comes from the SDRAM read path outside.
	assign data_valid = host.ce & ~host.we & (busy | identify);

endmodule

//--- src/write_fifo.sv
`timescale 1ns/1ps
`include "flash_consts.svh"

module write_fifo #(
	parameter type item_t = logic [7:0]
) (
	input  logic  clk,
	input  logic  reset,
	input  logic  push,
	input  logic  pop,
	input  item_t wr_item,
	output item_t rd_item,
	output logic  full,
	output logic  empty
);

	localparam int DEPTH = `WRITE_FIFO_DEPTH;
	localparam int PTR_W = $clog2(DEPTH);
	localparam logic [PTR_W:0] COUNT_FULL = (PTR_W + 1)'(DEPTH);

	item_t            mem [DEPTH];
	logic [PTR_W-1:0] rd_ptr;
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W:0]   count;
	logic             wr_en;
	logic             rd_en;

	function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
		return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
	endfunction

	assign full  = count == COUNT_FULL;
	assign empty = count == '0;
	assign wr_en = push & ~full;
	assign rd_en = pop & ~empty;

	assign rd_item = mem[rd_ptr]; // Head is always visible.

	always_ff @(posedge clk) begin
		if (reset) begin
			rd_ptr <= '0;
			wr_ptr <= '0;
			count  <= '0;
		end else begin
			if (wr_en)
				wr_ptr <= ptr_inc(wr_ptr);
			if (rd_en)
				rd_ptr <= ptr_inc(rd_ptr);
			case ({wr_en, rd_en})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: ;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (wr_en)
			mem[wr_ptr] <= wr_item;
	end

endmodule

//--- src/sdram_writer.sv
`timescale 1ns/1ps
`include "flash_consts.svh"

module sdram_writer
	import flash_pkg::*;
(
	input  logic                     clk,
	input  logic                     reset,
	input  write_item_t              item,
	input  logic                     empty,
	output logic                     pop,
	input  logic                     sdram_ready,
	input  logic                     sdram_done,
	input  logic [`SDRAM_ADDR_W-1:0] sdram_offset,
	output logic [`SDRAM_ADDR_W-1:0] sdram_addr,
	output logic [7:0]               sdram_din,
	output logic                     sdram_req,
	output logic                     busy
);

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_WAIT,
		ST_REQ
	} state_t;

	state_t                         state;
	logic [`FLASH_SECTOR_SHIFT-1:0] remaining;
	logic                           is_erase;
	logic [`FLASH_ADDR_W-1:0]       sector_base;
	logic [`FLASH_ADDR_W-1:0]       start_addr;
	logic                           last_done;

	// *********************************************************************
	// Item decode
	// *********************************************************************

	assign pop = (state == ST_IDLE) & ~empty;
	assign is_erase = item.kind == WR_ERASE;

	assign sector_base = {item.addr[`FLASH_ADDR_W-1:`FLASH_SECTOR_SHIFT],
		{`FLASH_SECTOR_SHIFT{1'b0}}};
	assign start_addr = is_erase ? sector_base : item.addr;

	// The write that ends the current item.
	assign last_done = (state == ST_REQ) & sdram_done & (remaining == '0);

	// *********************************************************************
	// Handshake control
	// *********************************************************************

	always_ff @(posedge clk) begin
		if (reset) begin
			state     <= ST_IDLE;
			sdram_req <= 1'b0;
			busy      <= 1'b0;
		end else begin
			case (state)
				ST_IDLE: begin
					if (pop) begin
						state <= ST_WAIT;
						busy  <= is_erase; // Only a sweep counts as busy.
					end
				end
				ST_WAIT: begin
					if (sdram_ready) begin
						sdram_req <= 1'b1;
						state     <= ST_REQ;
					end
				end
				ST_REQ: begin
					if (sdram_done) begin
						sdram_req <= 1'b0;
						state     <= last_done ? ST_IDLE : ST_WAIT;
						if (last_done)
							busy <= 1'b0;
					end
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

	// *********************************************************************
	// Address, data and write count
	// *********************************************************************

	always_ff @(posedge clk) begin
		if (pop) begin
			sdram_addr <= sdram_offset + `SDRAM_ADDR_W'(start_addr);
			sdram_din  <= is_erase ? 8'hFF : item.data;
			remaining  <= is_erase ? '1 : '0; // Writes left after the first.
		end else if (state == ST_REQ && sdram_done && !last_done) begin
			sdram_addr <= sdram_addr + 1'b1;
			remaining  <= remaining - 1'b1;
		end
	end

endmodule

//--- src/flash_emu.sv
`timescale 1ns/1ps
`include "flash_consts.svh"

module flash_emu
	import flash_pkg::*;
(
	input  logic                     clk,
	input  logic                     reset,
	input  host_bus_t                host,
	output logic [7:0]               dout,
	output logic                     data_valid,
	output logic                     overflow,
	input  logic                     sdram_ready,
	input  logic                     sdram_done,
	input  logic [`SDRAM_ADDR_W-1:0] sdram_offset,
	output logic [`SDRAM_ADDR_W-1:0] sdram_addr,
	output logic [7:0]               sdram_din,
	output logic                     sdram_req
);

	write_item_t push_item;
	write_item_t head_item;
	logic        push;
	logic        pop;
	logic        full;
	logic        empty;
	logic        busy;

	flash_cmd_decoder u_decoder (
		.clk        (clk),
		.reset      (reset),
		.host       (host),
		.busy       (busy),
		.dout       (dout),
		.data_valid (data_valid),
		.item       (push_item),
		.push       (push),
		.full       (full),
		.overflow   (overflow)
	);

	write_fifo #(.item_t(write_item_t)) u_fifo (
		.clk     (clk),
		.reset   (reset),
		.push    (push),
		.pop     (pop),
		.wr_item (push_item),
		.rd_item (head_item),
		.full    (full),
		.empty   (empty)
	);

	sdram_writer u_writer (
		.clk          (clk),
		.reset        (reset),
		.item         (head_item),
		.empty        (empty),
		.pop          (pop),
		.sdram_ready  (sdram_ready),
		.sdram_done   (sdram_done),
		.sdram_offset (sdram_offset),
		.sdram_addr   (sdram_addr),
		.sdram_din    (sdram_din),
		.sdram_req    (sdram_req),
		.busy         (busy)
	);

endmodule

//--- test/flash_checker.sv
`timescale 1ns/1ps
`include "flash_consts.svh"

module flash_checker (
	input logic                     clk,
	input logic                     reset,
	input logic [7:0]               dout,
	input logic                     data_valid,
	input logic                     overflow,
	input logic [`SDRAM_ADDR_W-1:0] sdram_addr,
	input logic [7:0]               sdram_din,
	input logic                     sdram_req,
	input logic                     sdram_done,
	input logic                     rd_check,
	input logic [8:0]               rd_expect,
	input logic [127:0]             test_name
);

	typedef struct packed {
		logic [127:0]             name;
		logic [`SDRAM_ADDR_W-1:0] addr;
		logic [7:0]               data;
	} sdram_write_t;

	sdram_write_t exp_q [$];
	sdram_write_t head;
	int           mismatches = 0;
	int           failures = 0;
	logic         overflow_seen = 1'b0;

	task automatic add_write(input logic [127:0] name, input logic [`SDRAM_ADDR_W-1:0] addr,
		input logic [7:0] data);
		exp_q.push_back({name, addr, data});
	endtask

	function automatic int pending();
		return exp_q.size();
	endfunction

	function automatic void report_failure(input string msg);
		$display("%s", msg);
		failures++;
	endfunction

	// *********************************************************************
	// SDRAM writes complete on req and done together; reads are checked
	// in the cycle they are held.
	// *********************************************************************

	always @(posedge clk) begin
		if (!reset && sdram_req && sdram_done) begin
			if (exp_q.size() == 0) begin
				report_failure($sformatf("unexpected SDRAM write of %h at address %h",
					sdram_din, sdram_addr));
			end else begin
				head = exp_q.pop_front();
				if (sdram_addr !== head.addr || sdram_din !== head.data) begin
					$display("mismatch %0s: expected %h at %h, actual %h at %h", head.name,
						head.data, head.addr, sdram_din, sdram_addr);
					mismatches++;
				end
			end
		end
		if (rd_check && {data_valid, dout} !== rd_expect) begin
			$display("mismatch %0s: expected valid %b dout %h, actual valid %b dout %h",
				test_name, rd_expect[8], rd_expect[7:0], data_valid, dout);
			mismatches++;
		end
		if (!reset && overflow && !overflow_seen) begin
			report_failure("overflow rose although the host waited for idle between groups");
			overflow_seen = 1'b1;
		end
	end

	function automatic int print_summary();
		if (exp_q.size() != 0)
			report_failure($sformatf("%0d expected SDRAM writes never arrived", exp_q.size()));
		$display("errors: %0d mismatches, %0d other failures", mismatches, failures);
		return mismatches + failures;
	endfunction

endmodule

//--- test/flash_emu_tb.sv
`timescale 1ns/1ps
`include "flash_consts.svh"

module flash_emu_tb
	import flash_pkg::*;
();

	localparam logic [`SDRAM_ADDR_W-1:0] SDRAM_OFFSET = 27'h0400000;

	typedef struct packed {
		logic [127:0]             name;
		logic [7:0]               op;
		logic [`FLASH_ADDR_W-1:0] addr;
		logic [7:0]               data;
		logic                     valid;
	} pattern_t;

	logic                     clk;
	logic                     reset;
	host_bus_t                host;
	logic                     sdram_ready;
	logic                     sdram_done;
	logic [7:0]               dout;
	logic                     data_valid;
	logic                     overflow;
	logic [`SDRAM_ADDR_W-1:0] sdram_addr;
	logic [7:0]               sdram_din;
	logic                     sdram_req;
	logic                     rd_check;
	logic [8:0]               rd_expect;
	logic [127:0]             test_name;
	logic [31:0]              lcg_state = 32'hecad;
	pattern_t                 patterns [$];
	int                       cycles = 0;
	int                       limit = 0;

	flash_emu dut (
		.clk, .reset, .host, .dout, .data_valid, .overflow,
		.sdram_ready, .sdram_done, .sdram_offset(SDRAM_OFFSET),
		.sdram_addr, .sdram_din, .sdram_req
	);

	flash_checker chk (
		.clk, .reset, .dout, .data_valid, .overflow,
		.sdram_addr, .sdram_din, .sdram_req, .sdram_done,
		.rd_check, .rd_expect, .test_name
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (limit > 0 && cycles >= limit) begin
			$display("timeout after %0d cycles, the DUT never finished its work", cycles);
			void'(chk.print_summary());
			$display("Regression failed");
			$finish;
		end
	end

	function automatic int lcg_next();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return int'(lcg_state[17:16]); // Delay of 0 to 3 cycles.
	endfunction

	task automatic step();
		@(posedge clk);
		#2;
	endtask

	task automatic bus_write(input logic [`FLASH_ADDR_W-1:0] addr, input logic [7:0] data);
		host = '{addr: addr, din: data, we: 1'b1, ce: 1'b1};
		step();
		host.we = 1'b0; // The next write needs we low for one cycle.
		host.ce = 1'b0;
		step();
	endtask

	task automatic bus_read(input logic [`FLASH_ADDR_W-1:0] addr, input logic [8:0] expect_bits);
		host = '{addr: addr, din: 8'h00, we: 1'b0, ce: 1'b1};
		rd_expect = expect_bits;
		rd_check = 1'b1;
		step();
		rd_check = 1'b0;
		host.ce = 1'b0;
	endtask

	// The writer is done when nothing is expected, queued or in progress.
	task automatic wait_idle();
		while (chk.pending() != 0 || !dut.empty || dut.u_writer.state != 2'd0)
			step();
	endtask

	task automatic run_pattern(input pattern_t pat);
		logic [`FLASH_ADDR_W-1:0] base;
		base = (pat.addr >> `FLASH_SECTOR_SHIFT) << `FLASH_SECTOR_SHIFT;
		test_name = pat.name;
		case (pat.op)
			"w": bus_write(pat.addr, pat.data);
			"r": bus_read(pat.addr, {pat.valid, pat.data});
			"p": chk.add_write(pat.name, SDRAM_OFFSET + `SDRAM_ADDR_W'(pat.addr), pat.data);
			"e": begin
				for (int i = 0; i < (1 << `FLASH_SECTOR_SHIFT); i++)
					chk.add_write(pat.name, SDRAM_OFFSET + `SDRAM_ADDR_W'(base) +
						`SDRAM_ADDR_W'(i), 8'hFF);
			end
			"i": wait_idle();
			default: chk.report_failure($sformatf("unknown opcode in test %0s", pat.name));
		endcase
	endtask

	// *********************************************************************
	// SDRAM model with random ready and done delays
	// *********************************************************************

	initial begin
		sdram_ready = 1'b0;
		sdram_done = 1'b0;
		@(negedge reset);
		forever begin
			repeat (lcg_next()) step();
			sdram_ready = 1'b1;
			step();
			while (!sdram_req)
				step();
			sdram_ready = 1'b0;
			repeat (lcg_next()) step();
			sdram_done = 1'b1;
			step();
			sdram_done = 1'b0;
		end
	end

	// *********************************************************************
	// Pattern playback
	// *********************************************************************

	initial begin : main
		int                       fd;
		int                       n;
		int                       erases;
		logic [127:0]             name;
		logic [7:0]               op;
		logic [`FLASH_ADDR_W-1:0] addr;
		logic [7:0]               data;
		logic                     valid;
		host = '0;
		reset = 1'b1;
		rd_check = 1'b0;
		rd_expect = '0;
		test_name = '0;
		erases = 0;
		fd = $fopen("test/flash_patterns.txt", "r");
		if (fd == 0) begin
			$display("cannot open the pattern file test/flash_patterns.txt");
			$display("Regression failed");
		end else begin
			n = $fscanf(fd, "%s %s %h %h %h", name, op, addr, data, valid);
			while (n == 5) begin
				patterns.push_back({name, op, addr, data, valid});
				if (op == "e")
					erases++;
				n = $fscanf(fd, "%s %s %h %h %h", name, op, addr, data, valid);
			end
			$fclose(fd);
			limit = (patterns.size() + erases * (1 << `FLASH_SECTOR_SHIFT)) * 8;
			repeat (2) @(posedge clk);
			#2 reset = 1'b0;
			foreach (patterns[k])
				run_pattern(patterns[k]);
			if (chk.print_summary() == 0)
				$display("Regression passed");
			else
				$display("Regression failed");
		end
		$finish;
	end

endmodule

//--- test/flash_patterns.txt
ident w aaa aa 0
ident w 554 55 0
ident w aaa 90 0
ident r 0 20 1
ident r 2 7e 1
ident r 4 00 1
ident r 6 01 1
ident w 0 f0 0
ident r 2 ff 0
prog1 w aaa aa 0
prog1 w 554 55 0
prog1 w aaa a0 0
prog1 p 1234 5a 0
prog1 w 1234 5a 0
prog1 i 0 0 0
prog2 w aaa 50 0
prog2 p 2000 11 0
prog2 p 2001 22 0
prog2 w 2000 11 0
prog2 w 2001 22 0
prog2 i 0 0 0
prog4 w aaa 56 0
prog4 p 3000 a1 0
prog4 p 3001 b2 0
prog4 p 3002 c3 0
prog4 p 3003 d4 0
prog4 w 3000 a1 0
prog4 w 3001 b2 0
prog4 w 3002 c3 0
prog4 w 3003 d4 0
bad w aaa aa 0
bad w 556 55 0
bad w aaa a0 0
bad w 1000 99 0
bad w aaa aa 0
bad w 554 44 0
bad w 1002 98 0
bad i 0 0 0
erase w aaa aa 0
erase w 554 55 0
erase w aaa 80 0
erase w aaa aa 0
erase w 554 55 0
erase e 5aaa 0 0
erase w 5aaa 30 0
erase r 5aaa 00 1
erase i 0 0 0

//--- compile.f
+incdir+src
src/flash_pkg.sv
src/flash_cmd_decoder.sv
src/write_fifo.sv
src/sdram_writer.sv
src/flash_emu.sv
test/flash_checker.sv
test/flash_emu_tb.sv

//--- run.sh
#!/bin/sh
# Builds the flash emulator testbench with Verilator and runs the regression.
cd "$(dirname "$0")" &&
verilator --binary --timing --top-module flash_emu_tb -f compile.f -o flash_emu_sim \
	> build.log 2>&1 &&
./obj_dir/flash_emu_sim > sim.log 2>&1 ||
{ cat build.log sim.log 2>/dev/null; echo "build or simulation did not complete"; exit 1; }
cat sim.log
grep -q "Regression passed" sim.log && exit 0 || exit 1
